/* verilog/cpu_pkg.sv */
// Shared widths, MIPS opcode and function codes for the word-only single-cycle core
`default_nettype none

package cpu_pkg;

  // --------------------------------------------------------------------
  localparam int unsigned xlen       = 32;      // Data and address width
  localparam int unsigned reg_addr_w = 5;       // Register index width

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  localparam reg_idx_t link_reg = 5'd31;        // Written by jal
  localparam word_t    reset_pc = '0;           // First fetch address

  // --------------------------------------------------------------------
  localparam logic [5:0] op_special = 6'b000000; // R-type, decoded by funct
  localparam logic [5:0] op_j       = 6'b000010;
  localparam logic [5:0] op_jal     = 6'b000011;
  localparam logic [5:0] op_beq     = 6'b000100;
  localparam logic [5:0] op_bne     = 6'b000101;
  localparam logic [5:0] op_addi    = 6'b001000;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_slti    = 6'b001010;
  localparam logic [5:0] op_sltiu   = 6'b001011;
  localparam logic [5:0] op_andi    = 6'b001100;
  localparam logic [5:0] op_ori     = 6'b001101;
  localparam logic [5:0] op_xori    = 6'b001110;
  localparam logic [5:0] op_lui     = 6'b001111;
  localparam logic [5:0] op_lw      = 6'b100011;
  localparam logic [5:0] op_sw      = 6'b101011;

  localparam logic [5:0] fn_sll  = 6'b000000;
  localparam logic [5:0] fn_srl  = 6'b000010;
  localparam logic [5:0] fn_sra  = 6'b000011;
  localparam logic [5:0] fn_sllv = 6'b000100;
  localparam logic [5:0] fn_srlv = 6'b000110;
  localparam logic [5:0] fn_srav = 6'b000111;
  localparam logic [5:0] fn_jr   = 6'b001000;
  localparam logic [5:0] fn_jalr = 6'b001001;
  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_xor  = 6'b100110;
  localparam logic [5:0] fn_nor  = 6'b100111;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_sltu = 6'b101011;

  // --------------------------------------------------------------------
  typedef enum logic [2:0] {
    alu_and  = 3'b000,
    alu_or   = 3'b001,
    alu_add  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_nor  = 3'b101,
    alu_sub  = 3'b110,
    alu_slt  = 3'b111
  } alu_op_t;

  typedef enum logic [1:0] {
    sh_sll = 2'b00,
    sh_srl = 2'b10,
    sh_sra = 2'b11                              // Arithmetic, sign fill
  } shift_op_t;

  typedef enum logic [2:0] {
    wb_alu   = 3'd0,
    wb_shift = 3'd1,
    wb_load  = 3'd2,
    wb_lui   = 3'd3,
    wb_link  = 3'd4                             // PC+8 for jal and jalr
  } wb_sel_t;

  // Three field layouts over the same instruction word
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } j;
  } instr_u;

endpackage

`default_nettype wire

/* verilog/cpu_decode.sv */
// Unknown opcodes and functions decode as a no-op that still lets the PC advance
`timescale 1ns/1ns
`default_nettype none

module cpu_decode (
  input  cpu_pkg::instr_u   instruction,
  output cpu_pkg::reg_idx_t rs_idx,
  output cpu_pkg::reg_idx_t rt_idx,
  output cpu_pkg::reg_idx_t wr_idx,
  output logic              reg_write,
  output logic              use_imm,      // Second operand from immediate
  output logic              zero_ext,     // Logical immediates
  output logic              use_shamt,    // Constant shift amount
  output logic              mem_read,
  output logic              mem_write,
  output logic              is_beq,
  output logic              is_bne,
  output logic              is_jump_imm,  // j, jal
  output logic              is_jump_reg,  // jr, jalr
  output cpu_pkg::alu_op_t  alu_op,
  output cpu_pkg::shift_op_t shift_op,
  output cpu_pkg::wb_sel_t  wb_sel
);

  assign rs_idx = instruction.r.rs;
  assign rt_idx = instruction.r.rt;

  always_comb begin
    wr_idx      = instruction.r.rt;       // Immediates and loads
    reg_write   = 1'b0;
    use_imm     = 1'b0;
    zero_ext    = 1'b0;
    use_shamt   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_beq      = 1'b0;
    is_bne      = 1'b0;
    is_jump_imm = 1'b0;
    is_jump_reg = 1'b0;
    alu_op      = cpu_pkg::alu_add;
    shift_op    = cpu_pkg::sh_sll;
    wb_sel      = cpu_pkg::wb_alu;

    case (instruction.r.opcode)
      cpu_pkg::op_special: begin
        wr_idx = instruction.r.rd;
        case (instruction.r.funct)
          cpu_pkg::fn_sll, cpu_pkg::fn_sllv: begin
            reg_write = 1'b1;
            wb_sel    = cpu_pkg::wb_shift;
            use_shamt = (instruction.r.funct == cpu_pkg::fn_sll);
          end
          cpu_pkg::fn_srl, cpu_pkg::fn_srlv: begin
            reg_write = 1'b1;
            wb_sel    = cpu_pkg::wb_shift;
            shift_op  = cpu_pkg::sh_srl;
            use_shamt = (instruction.r.funct == cpu_pkg::fn_srl);
          end
          cpu_pkg::fn_sra, cpu_pkg::fn_srav: begin
            reg_write = 1'b1;
            wb_sel    = cpu_pkg::wb_shift;
            shift_op  = cpu_pkg::sh_sra;
            use_shamt = (instruction.r.funct == cpu_pkg::fn_sra);
          end
          cpu_pkg::fn_jr:   is_jump_reg = 1'b1;          // No link
          cpu_pkg::fn_jalr: begin
            is_jump_reg = 1'b1;
            reg_write   = 1'b1;                          // Link goes to rd
            wb_sel      = cpu_pkg::wb_link;
          end
          cpu_pkg::fn_add, cpu_pkg::fn_addu: reg_write = 1'b1;
          cpu_pkg::fn_sub, cpu_pkg::fn_subu: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_sub;
          end
          cpu_pkg::fn_and: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_and;
          end
          cpu_pkg::fn_or: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_or;
          end
          cpu_pkg::fn_xor: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_xor;
          end
          cpu_pkg::fn_nor: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_nor;
          end
          cpu_pkg::fn_slt: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_slt;
          end
          cpu_pkg::fn_sltu: begin
            reg_write = 1'b1;
            alu_op    = cpu_pkg::alu_sltu;
          end
          default: ;                                     // Unknown funct is a no-op
        endcase
      end
      cpu_pkg::op_j:   is_jump_imm = 1'b1;
      cpu_pkg::op_jal: begin
        is_jump_imm = 1'b1;
        reg_write   = 1'b1;
        wr_idx      = cpu_pkg::link_reg;
        wb_sel      = cpu_pkg::wb_link;
      end
      cpu_pkg::op_beq: begin
        is_beq = 1'b1;
        alu_op = cpu_pkg::alu_sub;                       // Equal when difference is zero
      end
      cpu_pkg::op_bne: begin
        is_bne = 1'b1;
        alu_op = cpu_pkg::alu_sub;
      end
      cpu_pkg::op_addi, cpu_pkg::op_addiu: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
      end
      cpu_pkg::op_slti: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        alu_op    = cpu_pkg::alu_slt;
      end
      cpu_pkg::op_sltiu: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;                                // Sign-extended, unsigned compare
        alu_op    = cpu_pkg::alu_sltu;
      end
      cpu_pkg::op_andi: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        zero_ext  = 1'b1;
        alu_op    = cpu_pkg::alu_and;
      end
      cpu_pkg::op_ori: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        zero_ext  = 1'b1;
        alu_op    = cpu_pkg::alu_or;
      end
      cpu_pkg::op_xori: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        zero_ext  = 1'b1;
        alu_op    = cpu_pkg::alu_xor;
      end
      cpu_pkg::op_lui: begin
        reg_write = 1'b1;
        wb_sel    = cpu_pkg::wb_lui;
      end
      cpu_pkg::op_lw: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;                                // Base plus offset
        mem_read  = 1'b1;
        wb_sel    = cpu_pkg::wb_load;
      end
      cpu_pkg::op_sw: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/cpu_reg_file.sv */
// Register 0 reads as zero, reads are combinational and return the pre-write value
`timescale 1ns/1ns
`default_nettype none

module cpu_reg_file (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::reg_idx_t rs_idx,
  input  cpu_pkg::reg_idx_t rt_idx,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  logic              reg_write,
  input  cpu_pkg::word_t    wr_data,
  output cpu_pkg::word_t    rs_data,
  output cpu_pkg::word_t    rt_data
);

  cpu_pkg::word_t regs [2**cpu_pkg::reg_addr_w];  // Contents undefined after reset

  // Write port, blocked while in reset and for register 0
  always_ff @(posedge clk) begin
    if (!rst && reg_write && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];  // Hardwired zero
  assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

/* verilog/cpu_execute.sv */
// ALU and shifter only, no overflow or carry flags and no trap on signed overflow
`timescale 1ns/1ns
`default_nettype none

module cpu_execute (
  input  cpu_pkg::word_t     rs_data,
  input  cpu_pkg::word_t     rt_data,
  input  logic [15:0]        imm,
  input  logic [cpu_pkg::reg_addr_w-1:0] shamt,
  input  logic               use_imm,
  input  logic               zero_ext,
  input  logic               use_shamt,
  input  cpu_pkg::alu_op_t   alu_op,
  input  cpu_pkg::shift_op_t shift_op,
  output cpu_pkg::word_t     alu_result,
  output cpu_pkg::word_t     shift_result,
  output logic               zero
);

  cpu_pkg::word_t                imm_ext;
  cpu_pkg::word_t                op_b;
  logic [cpu_pkg::reg_addr_w-1:0] shift_amt;

  // --------------------------------------------------------------------
  assign imm_ext = zero_ext ? {{(cpu_pkg::xlen-16){1'b0}}, imm}
                            : {{(cpu_pkg::xlen-16){imm[15]}}, imm};  // Sign extend
  assign op_b    = use_imm ? imm_ext : rt_data;

  always_comb begin
    alu_result = '0;
    case (alu_op)
      cpu_pkg::alu_and:  alu_result = rs_data & op_b;
      cpu_pkg::alu_or:   alu_result = rs_data | op_b;
      cpu_pkg::alu_add:  alu_result = rs_data + op_b;   // Also address generation
      cpu_pkg::alu_xor:  alu_result = rs_data ^ op_b;
      cpu_pkg::alu_nor:  alu_result = ~(rs_data | op_b);
      cpu_pkg::alu_sub:  alu_result = rs_data - op_b;   // Branch compare
      cpu_pkg::alu_slt:  alu_result[0] = $signed(rs_data) < $signed(op_b);
      cpu_pkg::alu_sltu: alu_result[0] = rs_data < op_b;
      default: ;
    endcase
  end

  assign zero = (alu_result == '0);

  // --------------------------------------------------------------------
  assign shift_amt = use_shamt ? shamt : rs_data[cpu_pkg::reg_addr_w-1:0];  // Low bits only

  always_comb begin
    shift_result = '0;
    case (shift_op)
      cpu_pkg::sh_sll: shift_result = rt_data << shift_amt;
      cpu_pkg::sh_srl: shift_result = rt_data >> shift_amt;
      cpu_pkg::sh_sra: shift_result = $signed(rt_data) >>> shift_amt;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/cpu_fetch.sv */
// No branch delay slot, a taken branch or jump redirects the very next fetch
`timescale 1ns/1ns
`default_nettype none

module cpu_fetch (
  input  logic           clk,
  input  logic           rst,
  input  logic           is_beq,
  input  logic           is_bne,
  input  logic           is_jump_imm,
  input  logic           is_jump_reg,
  input  logic           zero,         // From ALU subtract of rs and rt
  input  logic [15:0]    imm,
  input  logic [25:0]    target,
  input  cpu_pkg::word_t rs_data,
  output cpu_pkg::word_t pc,
  output cpu_pkg::word_t link_pc
);

  cpu_pkg::word_t pc_plus4;
  cpu_pkg::word_t branch_target;
  cpu_pkg::word_t jump_target;
  cpu_pkg::word_t next_pc;
  logic           branch_taken;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};  // Word offset
  assign jump_target   = is_jump_reg ? rs_data : {pc[31:28], target, 2'b00};
  assign branch_taken  = (is_beq && zero) || (is_bne && !zero);

  // Jumps win over branches, then fall through
  assign next_pc = (is_jump_imm || is_jump_reg) ? jump_target   :
                   branch_taken                 ? branch_target :
                                                  pc_plus4;

  assign link_pc = pc + 32'd8;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= cpu_pkg::reset_pc;
    end else begin
      pc <= next_pc;                   // One instruction per clock
    end
  end

endmodule

`default_nettype wire

/* verilog/simple_cpu.sv */
// Memories must answer combinationally in the same cycle, stores always write a full word
`timescale 1ns/1ns
`default_nettype none

module simple_cpu (
  input  logic           clk,
  input  logic           rst,
  output cpu_pkg::word_t pc,
  input  cpu_pkg::word_t instruction,
  output cpu_pkg::word_t address,      // Word aligned
  output logic           mem_write,
  output cpu_pkg::word_t write_data,
  output logic           mem_read,
  input  cpu_pkg::word_t read_data
);

  // --------------------------------------------------------------------
  cpu_pkg::instr_u    instr_word;
  cpu_pkg::reg_idx_t  rs_idx;
  cpu_pkg::reg_idx_t  rt_idx;
  cpu_pkg::reg_idx_t  wr_idx;
  logic               reg_write;
  logic               use_imm;
  logic               zero_ext;
  logic               use_shamt;
  logic               is_beq;
  logic               is_bne;
  logic               is_jump_imm;
  logic               is_jump_reg;
  cpu_pkg::alu_op_t   alu_op;
  cpu_pkg::shift_op_t shift_op;
  cpu_pkg::wb_sel_t   wb_sel;
  cpu_pkg::word_t     rs_data;
  cpu_pkg::word_t     rt_data;
  cpu_pkg::word_t     alu_result;
  cpu_pkg::word_t     shift_result;
  logic               zero;
  cpu_pkg::word_t     link_pc;
  cpu_pkg::word_t     wr_data;

  assign instr_word = instruction;

  cpu_decode decode_i (
    .instruction (instr_word),
    .rs_idx      (rs_idx),
    .rt_idx      (rt_idx),
    .wr_idx      (wr_idx),
    .reg_write   (reg_write),
    .use_imm     (use_imm),
    .zero_ext    (zero_ext),
    .use_shamt   (use_shamt),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .is_beq      (is_beq),
    .is_bne      (is_bne),
    .is_jump_imm (is_jump_imm),
    .is_jump_reg (is_jump_reg),
    .alu_op      (alu_op),
    .shift_op    (shift_op),
    .wb_sel      (wb_sel)
  );

  cpu_reg_file reg_file_i (
    .clk       (clk),
    .rst       (rst),
    .rs_idx    (rs_idx),
    .rt_idx    (rt_idx),
    .wr_idx    (wr_idx),
    .reg_write (reg_write),
    .wr_data   (wr_data),
    .rs_data   (rs_data),
    .rt_data   (rt_data)
  );

  cpu_execute execute_i (
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .imm          (instr_word.i.imm),
    .shamt        (instr_word.r.shamt),
    .use_imm      (use_imm),
    .zero_ext     (zero_ext),
    .use_shamt    (use_shamt),
    .alu_op       (alu_op),
    .shift_op     (shift_op),
    .alu_result   (alu_result),
    .shift_result (shift_result),
    .zero         (zero)
  );

  cpu_fetch fetch_i (
    .clk         (clk),
    .rst         (rst),
    .is_beq      (is_beq),
    .is_bne      (is_bne),
    .is_jump_imm (is_jump_imm),
    .is_jump_reg (is_jump_reg),
    .zero        (zero),
    .imm         (instr_word.i.imm),
    .target      (instr_word.j.target),
    .rs_data     (rs_data),
    .pc          (pc),
    .link_pc     (link_pc)
  );

  // --------------------------------------------------------------------
  // Write-back source select
  always_comb begin
    case (wb_sel)
      cpu_pkg::wb_alu:   wr_data = alu_result;
      cpu_pkg::wb_shift: wr_data = shift_result;
      cpu_pkg::wb_load:  wr_data = read_data;                  // Whole word only
      cpu_pkg::wb_lui:   wr_data = {instr_word.i.imm, 16'h0000};
      cpu_pkg::wb_link:  wr_data = link_pc;
      default:           wr_data = alu_result;
    endcase
  end

  assign address    = {alu_result[cpu_pkg::xlen-1:2], 2'b00};  // Low bits dropped
  assign write_data = rt_data;

endmodule

`default_nettype wire

/* verif/simple_cpu_tb.sv */
// Runs from the project root, program limited to 64 words, data RAM covers byte addresses 0-3ff
`timescale 1ns/1ns
`default_nettype none

module simple_cpu_tb;

  // --------------------------------------------------------------------
  localparam int unsigned prog_words  = 64;    // Instruction ROM size in words
  localparam int unsigned res_base    = 64;    // Expected results start here
  localparam int unsigned input_depth = 128;
  localparam int unsigned ram_words   = 256;   // 1 KiB data RAM
  localparam int unsigned reset_cycles = 10;

  logic           clk;
  logic           rst;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t instruction;
  cpu_pkg::word_t address;
  logic           mem_write;
  cpu_pkg::word_t write_data;
  logic           mem_read;
  cpu_pkg::word_t read_data;

  cpu_pkg::word_t input_mem [input_depth];     // Program plus expected values
  cpu_pkg::word_t data_ram [ram_words];

  int unsigned    prog_len;
  int unsigned    store_count;                 // Number of expected stores
  int unsigned    store_idx;                   // Next expected store
  int unsigned    cycle_count = 0;
  int unsigned    cycle_limit;
  int unsigned    stable_cycles;
  int unsigned    word_idx;
  cpu_pkg::word_t final_pc;
  cpu_pkg::word_t last_pc;

  simple_cpu simple_cpu_i (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .instruction (instruction),
    .address     (address),
    .mem_write   (mem_write),
    .write_data  (write_data),
    .mem_read    (mem_read),
    .read_data   (read_data)
  );

  // --------------------------------------------------------------------
  always #50 clk = ~clk;                       // 100 ns period

  // Both memories answer in the same cycle
  assign instruction = input_mem[pc[7:2]];     // Program region only
  assign read_data   = data_ram[address[9:2]];

  always @(posedge clk) begin
    if (!rst && mem_write) begin
      data_ram[address[9:2]] <= write_data;    // Whole word
    end
  end

  // --------------------------------------------------------------------
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t expected,
                            input cpu_pkg::word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_pc(input cpu_pkg::word_t expected);
    if (pc !== expected) begin
      abort_run($sformatf("FAILED pc: expected %h, actual %h", expected, pc));
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // --------------------------------------------------------------------
  // Store monitor samples mid-cycle while outputs are settled
  always @(negedge clk) begin
    if (!rst) begin
      compare_bit("mem_read", instruction[31:26] == 6'b100011, mem_read);  // High only for lw
    end
    if (!rst && mem_write) begin
      if (store_idx >= store_count) begin
        abort_run($sformatf("Unexpected store to address %h after the last expected one",
                            address));
      end else begin
        check_word("address", input_mem[res_base + 2 + 2 * store_idx], address);
        check_word("write_data", input_mem[res_base + 3 + 2 * store_idx], write_data);
        store_idx = store_idx + 1;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1, "Run limit reached");
    end
  end

  // --------------------------------------------------------------------
  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    store_idx = 0;
    $readmemh("verif/program_input.txt", input_mem);
    prog_len    = input_mem[res_base];
    store_count = input_mem[res_base + 1];
    cycle_limit = 4 * prog_len + 40;           // Program length based
    if ($isunknown(input_mem[res_base + 1]) || (prog_len > prog_words)) begin
      abort_run("The stimulus file did not load or its header is invalid");
    end
    final_pc = input_mem[res_base + 2 + 2 * store_count];
    for (word_idx = 0; word_idx < ram_words; word_idx++) begin
      data_ram[word_idx] = 32'hda7a_0000 | (word_idx << 2);  // Address as fill
    end

    // Reset spans 10 rising edges and is checked just before release
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    check_pc(32'h0000_0000);
    compare_bit("mem_write", 1'b0, mem_write);
    @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_pc(32'h0000_0000);                   // First fetch at zero

    wait (store_idx == store_count);

    // Self loop reached when pc holds for two cycles
    last_pc       = pc;
    stable_cycles = 0;
    while (stable_cycles < 2) begin
      @(negedge clk);
      if (pc === last_pc) begin
        stable_cycles = stable_cycles + 1;
      end else begin
        stable_cycles = 0;
        last_pc       = pc;
      end
    end
    check_pc(final_pc);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* simple_cpu.f */
verilog/cpu_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_reg_file.sv
verilog/cpu_execute.sv
verilog/cpu_fetch.sv
verilog/simple_cpu.sv
verif/simple_cpu_tb.sv

/* Bender.yml */
package:
  name: simple_cpu

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_decode.sv
      - verilog/cpu_reg_file.sv
      - verilog/cpu_execute.sv
      - verilog/cpu_fetch.sv
      - verilog/simple_cpu.sv
  - target: simulation
    files:
      - verif/simple_cpu_tb.sv

/* verif/program_input.txt */
// Words 00-3f: program, four instruction words per line starting at the byte address shown
// Words 40 on: program length, store count, then per store its address and data, then final PC
@0
2001fffd 20020036 00221820 00222022  // 00: addi r1,r0,-3  addi r2,r0,0x36  add r3  sub r4
0022282a 0022302b ac030000 ac040004  // 10: slt r5  sltu r6  sw r3,0  sw r4,4
ac050008 ac06000c 00223824 00224025  // 20: sw r5,8  sw r6,12  and r7  or r8
00224826 00225027 ac070010 ac080014  // 30: xor r9  nor r10  sw r7,16  sw r8,20
ac090018 ac0a001c 00025900 00016043  // 40: sw r9  sw r10  sll r11,r2,4  sra r12,r1,1
00016f02 00417004 00417806 00418007  // 50: srl r13,r1,28  sllv r14  srlv r15  srav r16
ac0b0020 ac0c0024 ac0d0028 ac0e002c  // 60: sw r11  sw r12  sw r13  sw r14
ac0f0030 ac100034 2831fffe 3032ff00  // 70: sw r15  sw r16  slti r17,r1,-2  andi r18,r1,0xff00
34138001 38348000 3c151234 36b55678  // 80: ori r19,r0,0x8001  xori r20  lui r21  ori r21
20000007 ac110038 ac12003c ac130040  // 90: addi r0,r0,7  sw r17  sw r18  sw r19
ac140044 ac150048 ac00004c 8c560012  // a0: sw r20  sw r21  sw r0  lw r22,0x12(r2)
ac160080 10220001 ac020084 14220001  // b0: sw r22  beq r1,r2 not taken  sw r2  bne r1,r2 taken
ac000088 10630001 ac010088 14630001  // c0: skipped  beq r3,r3 taken  skipped  bne r3,r3
ac03008c 0c00003c ac000090 201800f8  // d0: sw r3  jal 0xf0  skipped  addi r24,r0,0xf8
0300c809 ac000094 ac190098 0800003b  // e0: jalr r25,r24  skipped  sw r25  j 0xec
ac1f009c 03e00008 ac1800a0 03200008  // f0: sw r31  jr r31  sw r24  jr r25
@40
00000040 0000001a  // program length, store count
00000000 00000033  // add
00000004 ffffffc7  // sub
00000008 00000001  // slt signed
0000000c 00000000  // sltu unsigned
00000010 00000034  // and
00000014 ffffffff  // or
00000018 ffffffcb  // xor
0000001c 00000000  // nor
00000020 00000360  // sll
00000024 fffffffe  // sra sign fill
00000028 0000000f  // srl
0000002c ff400000  // sllv by 22
00000030 000003ff  // srlv by 22
00000034 ffffffff  // srav by 22
00000038 00000001  // slti sign extended
0000003c 0000ff00  // andi zero extended
00000040 00008001  // ori zero extended
00000044 ffff7ffd  // xori zero extended
00000048 12345678  // lui then ori
0000004c 00000000  // write to r0 lost
00000080 12345678  // lw of stored word
00000084 00000036  // after beq not taken
0000008c 00000033  // after bne not taken
0000009c 000000dc  // jal link
000000a0 000000f8  // reached through jalr
00000098 000000e8  // jalr link
000000ec           // final PC
